// ==== rtl/vec_pkg.sv ====
package vec_pkg;

    // Frontend and issue widths
    parameter int ISSUE_LANE = 4;
    parameter int NUM_ISSUE  = 2;

    // Vector shape with LMUL fixed at 1
    parameter int VLEN      = 64;
    parameter int SEW       = 8;
    parameter int NUM_ELEM  = VLEN / SEW;
    parameter int NUM_VREG  = 32;
    parameter int REG_IDX_W = 5;
    parameter int XLEN      = 32;

    parameter int CQ_DEPTH = 8;

    typedef enum logic [2:0] {
        VMV_VX    = 3'd0,
        VADD_VV   = 3'd1,
        VADD_VX   = 3'd2,
        VSUB_VV   = 3'd3,
        VSADDU_VV = 3'd4,
        VAND_VV   = 3'd5
    } vec_op_e;

    // Command as offered by the scalar core
    typedef struct packed {
        vec_op_e              op;
        logic [REG_IDX_W-1:0] vd;
        logic [REG_IDX_W-1:0] vs1;
        logic [REG_IDX_W-1:0] vs2;
        logic [XLEN-1:0]      scalar;
    } vec_cmd_t;

    // Issued micro-op with operand vectors already read
    typedef struct packed {
        vec_op_e              op;
        logic [REG_IDX_W-1:0] vd;
        logic [VLEN-1:0]      src1;
        logic [VLEN-1:0]      src2;
        logic [SEW-1:0]       scalar;
    } vec_uop_t;

    // ALU result
    typedef struct packed {
        logic [REG_IDX_W-1:0] vd;
        logic [VLEN-1:0]      data;
        logic                 sat_op;
        logic                 sat;
    } vec_res_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0] vd;
        logic [VLEN-1:0]      data;
    } vec_rt_t;

endpackage

// ==== rtl/fifo_4w2r.sv ====
`timescale 1ns/100ps

module fifo_4w2r #(
    parameter int DWIDTH = 8,
    parameter int DEPTH  = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [3:0]                 push,
    input  logic [3:0][DWIDTH-1:0]     in_data,
    input  logic [1:0]                 pop,
    output logic [1:0][DWIDTH-1:0]     out_data,
    output logic [3:0]                 ready,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DWIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  free;
    logic [3:0]        push_acc;
    logic [2:0]        push_num;
    logic [1:0]        pop_num;

    // Pointer advance with wrap at DEPTH
    function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] p, input int n);
        int s;
        s = int'(p) + n;
        if (s >= DEPTH) begin
            s = s - DEPTH;
        end
        return PTR_W'(s);
    endfunction

    assign free = CNT_W'(DEPTH) - count;

    // Lane k is ready with at least k+1 free entries
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            ready[k] = free > CNT_W'(k);
        end
    end

    assign push_acc = push & ready;
    assign push_num = 3'($countones(push_acc));
    assign pop_num  = 2'($countones(pop));

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            out_data[i] = mem[ptr_add(rd_ptr, i)];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (push_acc[i]) begin
                mem[ptr_add(wr_ptr, i)] <= in_data[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= ptr_add(wr_ptr, int'(push_num));
            rd_ptr <= ptr_add(rd_ptr, int'(pop_num));
            count  <= count + CNT_W'(push_num) - CNT_W'(pop_num);
        end
    end

    a_push_prefix: assert property (@(posedge clk) disable iff (!rst_n)
        push inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
        else $error("fifo_4w2r: push lanes not a prefix %b", push);

    a_pop_prefix: assert property (@(posedge clk) disable iff (!rst_n)
        (pop inside {2'b00, 2'b01, 2'b11}) && (CNT_W'(pop_num) <= count))
        else $error("fifo_4w2r: bad pop %b with count %0d", pop, count);

endmodule

// ==== rtl/vec_decode.sv ====
`timescale 1ns/100ps

module vec_decode #(
    parameter int CNT_W = 4
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  vec_pkg::vec_cmd_t [vec_pkg::NUM_ISSUE-1:0] cq_data,
    input  logic [CNT_W-1:0]                           cq_count,
    output logic [vec_pkg::NUM_ISSUE-1:0]              pop,
    output logic [3:0][vec_pkg::REG_IDX_W-1:0]         rd_idx,
    input  logic [3:0][vec_pkg::VLEN-1:0]              rd_data,
    output logic [vec_pkg::NUM_ISSUE-1:0]              issue_valid,
    output vec_pkg::vec_uop_t [vec_pkg::NUM_ISSUE-1:0] issue_uop
);

    logic [vec_pkg::NUM_ISSUE-1:0] use_vs1;
    logic [vec_pkg::NUM_ISSUE-1:0] use_vs2;
    logic [vec_pkg::NUM_ISSUE-1:0] blocked;
    logic                          pair_raw;
    logic [vec_pkg::NUM_VREG-1:0]  busy_dec;
    logic [vec_pkg::NUM_VREG-1:0]  busy_alu;
    logic [vec_pkg::NUM_VREG-1:0]  busy;
    logic [vec_pkg::NUM_VREG-1:0]  dest_mask;
    logic                          raw_in_flight;

    // Destinations held in this stage and in the ALU stage
    assign busy = busy_dec | busy_alu;

    always_comb begin
        for (int s = 0; s < vec_pkg::NUM_ISSUE; s++) begin
            use_vs1[s] = cq_data[s].op inside {vec_pkg::VADD_VV, vec_pkg::VSUB_VV,
                                               vec_pkg::VSADDU_VV, vec_pkg::VAND_VV};
            use_vs2[s] = cq_data[s].op != vec_pkg::VMV_VX;
            rd_idx[2*s]   = cq_data[s].vs1;
            rd_idx[2*s+1] = cq_data[s].vs2;
            blocked[s] = (use_vs1[s] && busy[cq_data[s].vs1]) ||
                         (use_vs2[s] && busy[cq_data[s].vs2]);
        end
    end

    // Slot 1 must not read what slot 0 writes
    assign pair_raw = (use_vs1[1] && cq_data[1].vs1 == cq_data[0].vd) ||
                      (use_vs2[1] && cq_data[1].vs2 == cq_data[0].vd);

    assign pop[0] = (cq_count != '0) && !blocked[0];
    assign pop[1] = pop[0] && (cq_count > CNT_W'(1)) && !blocked[1] && !pair_raw;

    always_comb begin
        dest_mask = '0;
        for (int s = 0; s < vec_pkg::NUM_ISSUE; s++) begin
            if (pop[s]) begin
                dest_mask[cq_data[s].vd] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= '0;
            busy_dec    <= '0;
            busy_alu    <= '0;
        end else begin
            issue_valid <= pop;
            busy_dec    <= dest_mask;
            busy_alu    <= busy_dec;
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < vec_pkg::NUM_ISSUE; s++) begin
            if (pop[s]) begin
                issue_uop[s].op     <= cq_data[s].op;
                issue_uop[s].vd     <= cq_data[s].vd;
                issue_uop[s].src1   <= rd_data[2*s];
                issue_uop[s].src2   <= rd_data[2*s+1];
                issue_uop[s].scalar <= cq_data[s].scalar[vec_pkg::SEW-1:0];
            end
        end
    end

    // Cross-check of the scoreboard against the issue register contents
    always_comb begin
        raw_in_flight = 1'b0;
        for (int s = 0; s < vec_pkg::NUM_ISSUE; s++) begin
            for (int j = 0; j < vec_pkg::NUM_ISSUE; j++) begin
                if (pop[s] && issue_valid[j] &&
                    ((use_vs1[s] && cq_data[s].vs1 == issue_uop[j].vd) ||
                     (use_vs2[s] && cq_data[s].vs2 == issue_uop[j].vd))) begin
                    raw_in_flight = 1'b1;
                end
            end
        end
    end

    a_no_raw_issue: assert property (@(posedge clk) disable iff (!rst_n) !raw_in_flight)
        else $error("vec_decode: issued a source still in flight");

endmodule

// ==== rtl/vec_alu.sv ====
`timescale 1ns/100ps

module vec_alu (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [vec_pkg::NUM_ISSUE-1:0]              issue_valid,
    input  vec_pkg::vec_uop_t [vec_pkg::NUM_ISSUE-1:0] issue_uop,
    output logic [vec_pkg::NUM_ISSUE-1:0]              alu_valid,
    output vec_pkg::vec_res_t [vec_pkg::NUM_ISSUE-1:0] alu_res
);

    vec_pkg::vec_res_t [vec_pkg::NUM_ISSUE-1:0] res;

    always_comb begin
        logic [vec_pkg::SEW-1:0] a;
        logic [vec_pkg::SEW-1:0] b;
        logic [vec_pkg::SEW:0]   sum;
        for (int s = 0; s < vec_pkg::NUM_ISSUE; s++) begin
            res[s].vd     = issue_uop[s].vd;
            res[s].data   = '0;
            res[s].sat_op = issue_uop[s].op == vec_pkg::VSADDU_VV;
            res[s].sat    = 1'b0;
            for (int e = 0; e < vec_pkg::NUM_ELEM; e++) begin
                a   = issue_uop[s].src1[e*vec_pkg::SEW +: vec_pkg::SEW];
                b   = issue_uop[s].src2[e*vec_pkg::SEW +: vec_pkg::SEW];
                sum = {1'b0, a} + {1'b0, b};
                case (issue_uop[s].op)
                    vec_pkg::VMV_VX:  res[s].data[e*vec_pkg::SEW +: vec_pkg::SEW] = issue_uop[s].scalar;
                    vec_pkg::VADD_VX: res[s].data[e*vec_pkg::SEW +: vec_pkg::SEW] = b + issue_uop[s].scalar;
                    vec_pkg::VADD_VV: res[s].data[e*vec_pkg::SEW +: vec_pkg::SEW] = sum[vec_pkg::SEW-1:0];
                    // vs2 minus vs1
                    vec_pkg::VSUB_VV: res[s].data[e*vec_pkg::SEW +: vec_pkg::SEW] = b - a;
                    vec_pkg::VSADDU_VV: begin
                        res[s].data[e*vec_pkg::SEW +: vec_pkg::SEW] =
                            sum[vec_pkg::SEW] ? '1 : sum[vec_pkg::SEW-1:0];
                        res[s].sat = res[s].sat | sum[vec_pkg::SEW];
                    end
                    vec_pkg::VAND_VV: res[s].data[e*vec_pkg::SEW +: vec_pkg::SEW] = a & b;
                    default:          res[s].data[e*vec_pkg::SEW +: vec_pkg::SEW] = '0;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_valid <= '0;
        end else begin
            alu_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < vec_pkg::NUM_ISSUE; s++) begin
            if (issue_valid[s]) begin
                alu_res[s] <= res[s];
            end
        end
    end

endmodule

// ==== rtl/vec_vrf.sv ====
`timescale 1ns/100ps

module vec_vrf (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic [3:0][vec_pkg::REG_IDX_W-1:0]        rd_idx,
    output logic [3:0][vec_pkg::VLEN-1:0]             rd_data,
    input  logic [vec_pkg::NUM_ISSUE-1:0]             wr_valid,
    input  vec_pkg::vec_rt_t [vec_pkg::NUM_ISSUE-1:0] wr_data
);

    logic [vec_pkg::VLEN-1:0] vreg [vec_pkg::NUM_VREG];

    // Combinational read ports
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rd_data[i] = vreg[rd_idx[i]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < vec_pkg::NUM_VREG; r++) begin
                vreg[r] <= '0;
            end
        end else begin
            // Younger slot written last so it wins on the same index
            for (int s = 0; s < vec_pkg::NUM_ISSUE; s++) begin
                if (wr_valid[s]) begin
                    vreg[wr_data[s].vd] <= wr_data[s].data;
                end
            end
        end
    end

endmodule

// ==== rtl/vec_retire.sv ====
`timescale 1ns/100ps

module vec_retire (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic [vec_pkg::NUM_ISSUE-1:0]              alu_valid,
    input  vec_pkg::vec_res_t [vec_pkg::NUM_ISSUE-1:0] alu_res,
    output logic [vec_pkg::NUM_ISSUE-1:0]              wr_valid,
    output vec_pkg::vec_rt_t [vec_pkg::NUM_ISSUE-1:0]  wr_data,
    output logic [vec_pkg::NUM_ISSUE-1:0]              rt_valid,
    output vec_pkg::vec_rt_t [vec_pkg::NUM_ISSUE-1:0]  rt,
    output logic                                       wr_vxsat_valid,
    output logic                                       wr_vxsat
);

    vec_pkg::vec_rt_t [vec_pkg::NUM_ISSUE-1:0] rec;
    logic [vec_pkg::NUM_ISSUE-1:0]             sat_op_vld;
    logic [vec_pkg::NUM_ISSUE-1:0]             sat_hit;

    always_comb begin
        for (int s = 0; s < vec_pkg::NUM_ISSUE; s++) begin
            rec[s].vd     = alu_res[s].vd;
            rec[s].data   = alu_res[s].data;
            sat_op_vld[s] = alu_valid[s] && alu_res[s].sat_op;
            sat_hit[s]    = sat_op_vld[s] && alu_res[s].sat;
        end
    end

    // VRF update at the same edge as the retire strobe
    assign wr_valid = alu_valid;
    assign wr_data  = rec;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rt_valid       <= '0;
            wr_vxsat_valid <= 1'b0;
            wr_vxsat       <= 1'b0;
        end else begin
            rt_valid       <= alu_valid;
            wr_vxsat_valid <= |sat_op_vld;
            wr_vxsat       <= |sat_hit;
        end
    end

    always_ff @(posedge clk) begin
        rt <= rec;
    end

    // Holds only if decode pops in order and the pipe keeps slot order
    a_rt_prefix: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid inside {2'b00, 2'b01, 2'b11})
        else $error("vec_retire: retire slots out of order %b", rt_valid);

endmodule

// ==== rtl/vec_backend.sv ====
`timescale 1ns/100ps

module vec_backend #(
    parameter int CQ_DEPTH = vec_pkg::CQ_DEPTH
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [vec_pkg::ISSUE_LANE-1:0]              insts_valid,
    input  vec_pkg::vec_cmd_t [vec_pkg::ISSUE_LANE-1:0] insts,
    output logic [vec_pkg::ISSUE_LANE-1:0]              insts_ready,
    output logic [vec_pkg::NUM_ISSUE-1:0]               rt_valid,
    output vec_pkg::vec_rt_t [vec_pkg::NUM_ISSUE-1:0]   rt,
    output logic                                        wr_vxsat_valid,
    output logic                                        wr_vxsat
);

    localparam int CNT_W = $clog2(CQ_DEPTH + 1);

    vec_pkg::vec_cmd_t [vec_pkg::NUM_ISSUE-1:0] cq_data;
    logic [CNT_W-1:0]                           cq_count;
    logic [vec_pkg::NUM_ISSUE-1:0]              pop;
    logic [3:0][vec_pkg::REG_IDX_W-1:0]         rd_idx;
    logic [3:0][vec_pkg::VLEN-1:0]              rd_data;
    logic [vec_pkg::NUM_ISSUE-1:0]              issue_valid;
    vec_pkg::vec_uop_t [vec_pkg::NUM_ISSUE-1:0] issue_uop;
    logic [vec_pkg::NUM_ISSUE-1:0]              alu_valid;
    vec_pkg::vec_res_t [vec_pkg::NUM_ISSUE-1:0] alu_res;
    logic [vec_pkg::NUM_ISSUE-1:0]              wr_valid;
    vec_pkg::vec_rt_t [vec_pkg::NUM_ISSUE-1:0]  wr_data;

    // Command queue qualifies valid with its own ready
    fifo_4w2r #(
        .DWIDTH   ($bits(vec_pkg::vec_cmd_t)),
        .DEPTH    (CQ_DEPTH)
    ) u_cmd_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (insts_valid),
        .in_data  (insts),
        .pop      (pop),
        .out_data (cq_data),
        .ready    (insts_ready),
        .count    (cq_count)
    );

    vec_decode #(
        .CNT_W (CNT_W)
    ) u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .cq_data     (cq_data),
        .cq_count    (cq_count),
        .pop         (pop),
        .rd_idx      (rd_idx),
        .rd_data     (rd_data),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop)
    );

    vec_alu u_alu (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop),
        .alu_valid   (alu_valid),
        .alu_res     (alu_res)
    );

    vec_vrf u_vrf (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data),
        .wr_valid (wr_valid),
        .wr_data  (wr_data)
    );

    vec_retire u_retire (
        .clk            (clk),
        .rst_n          (rst_n),
        .alu_valid      (alu_valid),
        .alu_res        (alu_res),
        .wr_valid       (wr_valid),
        .wr_data        (wr_data),
        .rt_valid       (rt_valid),
        .rt             (rt),
        .wr_vxsat_valid (wr_vxsat_valid),
        .wr_vxsat       (wr_vxsat)
    );

endmodule

// ==== sim/tb_vec_backend.sv ====
`timescale 1ns/100ps

module tb_vec_backend;

    localparam int NUM_GROUPS = 11;
    localparam int MAX_CYCLES = 40 * NUM_GROUPS + 100;

    logic                                        clk;
    logic                                        rst_n;
    logic [vec_pkg::ISSUE_LANE-1:0]              insts_valid;
    vec_pkg::vec_cmd_t [vec_pkg::ISSUE_LANE-1:0] insts;
    logic [vec_pkg::ISSUE_LANE-1:0]              insts_ready;
    logic [vec_pkg::NUM_ISSUE-1:0]               rt_valid;
    vec_pkg::vec_rt_t [vec_pkg::NUM_ISSUE-1:0]   rt;
    logic                                        wr_vxsat_valid;
    logic                                        wr_vxsat;

    // Stimulus table, one command group per entry
    int                grp_n    [NUM_GROUPS];
    string             grp_name [NUM_GROUPS];
    vec_pkg::vec_cmd_t grp_cmd  [NUM_GROUPS][4];

    // Golden register file and expected retire stream in program order
    logic [vec_pkg::VLEN-1:0] gold [vec_pkg::NUM_VREG];
    vec_pkg::vec_rt_t         exp_rec    [$];
    logic                     exp_sat_op [$];
    logic                     exp_sat    [$];
    string                    exp_name   [$];

    integer seed;
    int     errors;
    int     accepted;
    int     retired;
    int     stalls;
    int     cycles;

    vec_backend #(
        .CQ_DEPTH (vec_pkg::CQ_DEPTH)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .insts_valid    (insts_valid),
        .insts          (insts),
        .insts_ready    (insts_ready),
        .rt_valid       (rt_valid),
        .rt             (rt),
        .wr_vxsat_valid (wr_vxsat_valid),
        .wr_vxsat       (wr_vxsat)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d records outstanding",
                     cycles, exp_rec.size());
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic is_prefix(input logic [3:0] v);
        return v inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111};
    endfunction

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    function automatic logic [7:0] rand_byte();
        return 8'(rand_below(256));
    endfunction

    task automatic put(input int g, input int lane, input string name,
                       input vec_pkg::vec_op_e op, input int vd, input int vs1,
                       input int vs2, input logic [7:0] sc);
        grp_cmd[g][lane].op     = op;
        grp_cmd[g][lane].vd     = 5'(vd);
        grp_cmd[g][lane].vs1    = 5'(vs1);
        grp_cmd[g][lane].vs2    = 5'(vs2);
        // Upper scalar bits are noise, only the low byte matters
        grp_cmd[g][lane].scalar = {rand_byte(), rand_byte(), rand_byte(), sc};
        grp_name[g]             = name;
        grp_n[g]                = lane + 1;
    endtask

    task automatic build_table();
        vec_pkg::vec_op_e op;
        for (int k = 0; k < 4; k++) begin
            put(0, k, "splat", vec_pkg::VMV_VX, k + 1, 0, 0, rand_byte());
        end
        // Chain reading earlier destinations inside the group
        put(1, 0, "arith", vec_pkg::VADD_VV, 5, 1, 2, 8'h00);
        put(1, 1, "arith", vec_pkg::VSUB_VV, 6, 3, 5, 8'h00);
        put(1, 2, "arith", vec_pkg::VADD_VX, 7, 0, 6, rand_byte());
        put(1, 3, "arith", vec_pkg::VAND_VV, 8, 4, 7, 8'h00);
        // Across groups, with v9 written twice back to back
        put(2, 0, "arith", vec_pkg::VADD_VV, 9, 8, 5, 8'h00);
        put(2, 1, "arith", vec_pkg::VADD_VX, 9, 0, 1, rand_byte());
        put(2, 2, "arith", vec_pkg::VSUB_VV, 10, 2, 9, 8'h00);
        put(2, 3, "arith", vec_pkg::VAND_VV, 11, 9, 10, 8'h00);
        // Top bit set in both operands forces a clamp
        put(3, 0, "sat", vec_pkg::VMV_VX, 12, 0, 0, rand_byte() | 8'h80);
        put(3, 1, "sat", vec_pkg::VMV_VX, 13, 0, 0, rand_byte() | 8'h80);
        put(3, 2, "sat", vec_pkg::VSADDU_VV, 14, 12, 13, 8'h00);
        put(3, 3, "sat", vec_pkg::VMV_VX, 15, 0, 0, rand_byte() & 8'h3f);
        put(4, 0, "nosat", vec_pkg::VMV_VX, 16, 0, 0, rand_byte() & 8'h3f);
        put(4, 1, "nosat", vec_pkg::VSADDU_VV, 17, 15, 16, 8'h00);
        put(4, 2, "sat_rand", vec_pkg::VSADDU_VV, 18, 17, 7, 8'h00);
        put(4, 3, "sat_rand", vec_pkg::VADD_VV, 19, 14, 1, 8'h00);
        // Random burst over eight registers so hazards are frequent
        for (int g = 5; g < NUM_GROUPS; g++) begin
            for (int k = 0; k < ((g == 8) ? 3 : 4); k++) begin
                op = vec_pkg::vec_op_e'(3'(rand_below(6)));
                put(g, k, "burst", op, 20 + rand_below(8), 20 + rand_below(8),
                    20 + rand_below(8), rand_byte());
            end
        end
    endtask

    // Element rules of the ISA, applied in acceptance order
    task automatic model_accept(input vec_pkg::vec_cmd_t c, input string name);
        logic [63:0]      v1;
        logic [63:0]      v2;
        logic [63:0]      r;
        logic [7:0]       x;
        logic [7:0]       y;
        logic [7:0]       k;
        logic             sat;
        int               t;
        vec_pkg::vec_rt_t rec;
        v1  = gold[c.vs1];
        v2  = gold[c.vs2];
        k   = c.scalar[7:0];
        r   = '0;
        sat = 1'b0;
        for (int e = 0; e < 8; e++) begin
            x = v1[e*8 +: 8];
            y = v2[e*8 +: 8];
            case (c.op)
                vec_pkg::VMV_VX:  r[e*8 +: 8] = k;
                vec_pkg::VADD_VX: r[e*8 +: 8] = y + k;
                vec_pkg::VADD_VV: r[e*8 +: 8] = x + y;
                vec_pkg::VSUB_VV: r[e*8 +: 8] = y - x;
                vec_pkg::VAND_VV: r[e*8 +: 8] = x & y;
                vec_pkg::VSADDU_VV: begin
                    t = int'(x) + int'(y);
                    if (t > 255) begin
                        r[e*8 +: 8] = 8'hff;
                        sat = 1'b1;
                    end else begin
                        r[e*8 +: 8] = t[7:0];
                    end
                end
                default: r[e*8 +: 8] = 8'h00;
            endcase
        end
        gold[c.vd] = r;
        rec.vd     = c.vd;
        rec.data   = r;
        exp_rec.push_back(rec);
        exp_sat_op.push_back(c.op == vec_pkg::VSADDU_VV);
        exp_sat.push_back(sat);
        exp_name.push_back(name);
        accepted++;
    endtask

    // Present the group, shifting leftover lanes down until all are taken
    task automatic apply_group(input int g);
        int pend;
        int base;
        int take;
        pend = grp_n[g];
        base = 0;
        while (pend > 0) begin
            for (int k = 0; k < 4; k++) begin
                insts_valid[k] = k < pend;
                insts[k]       = '0;
                if (k < pend) begin
                    insts[k] = grp_cmd[g][base + k];
                end
            end
            assert (is_prefix(insts_ready))
            else begin
                errors++;
                $display("ERR %s: insts_ready expected a prefix actual %b",
                         grp_name[g], insts_ready);
            end
            if (insts_ready != 4'b1111) begin
                stalls++;
            end
            take = 0;
            for (int k = 0; k < 4; k++) begin
                if (insts_ready[k] && k < pend) begin
                    take++;
                end
            end
            @(posedge clk);
            #1;
            for (int k = 0; k < take; k++) begin
                model_accept(grp_cmd[g][base + k], grp_name[g]);
            end
            base = base + take;
            pend = pend - take;
        end
    endtask

    // Retire monitor, slot 0 is the older record
    always @(negedge clk) begin
        vec_pkg::vec_rt_t want;
        logic             want_vv;
        logic             want_v;
        string            name;
        if (!rst_n) begin
            assert (rt_valid == '0 && !wr_vxsat_valid)
            else begin
                errors++;
                $display("Retire or vxsat strobe raised during reset");
            end
        end else begin
            want_vv = 1'b0;
            want_v  = 1'b0;
            name    = "idle";
            for (int s = 0; s < vec_pkg::NUM_ISSUE; s++) begin
                if (rt_valid[s]) begin
                    retired++;
                    assert (exp_rec.size() != 0)
                    else begin
                        errors++;
                        $display("Retire on slot %0d with no command outstanding", s);
                    end
                    if (exp_rec.size() != 0) begin
                        want    = exp_rec.pop_front();
                        name    = exp_name.pop_front();
                        want_vv = want_vv | exp_sat_op.pop_front();
                        want_v  = want_v | exp_sat.pop_front();
                        assert (rt[s] == want)
                        else begin
                            errors++;
                            $display("ERR %s: slot %0d expected %h actual %h",
                                     name, s, want, rt[s]);
                        end
                    end
                end
            end
            assert (wr_vxsat_valid == want_vv)
            else begin
                errors++;
                $display("ERR %s: wr_vxsat_valid expected %b actual %b",
                         name, want_vv, wr_vxsat_valid);
            end
            if (want_vv) begin
                assert (wr_vxsat == want_v)
                else begin
                    errors++;
                    $display("ERR %s: wr_vxsat expected %b actual %b", name, want_v, wr_vxsat);
                end
            end
        end
    end

    initial begin
        seed        = 55620;
        clk         = 1'b0;
        rst_n       = 1'b0;
        insts_valid = '0;
        insts       = '0;
        errors      = 0;
        accepted    = 0;
        retired     = 0;
        stalls      = 0;
        cycles      = 0;
        for (int r = 0; r < vec_pkg::NUM_VREG; r++) begin
            gold[r] = '0;
        end
        build_table();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (insts_ready == 4'b1111)
        else begin
            errors++;
            $display("ERR reset: insts_ready expected 1111 actual %b", insts_ready);
        end
        for (int g = 0; g < NUM_GROUPS; g++) begin
            apply_group(g);
        end
        insts_valid = '0;
        // Drain, then watch a few more cycles for stray retires
        while (exp_rec.size() != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        assert (retired == accepted)
        else begin
            errors++;
            $display("ERR burst: retired count expected %0d actual %0d", accepted, retired);
        end
        assert (stalls > 0)
        else begin
            errors++;
            $display("Command queue never applied back-pressure");
        end
        $display("Errors %0d, accepted %0d, retired %0d, stall cycles %0d",
                 errors, accepted, retired, stalls);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== vec_backend.f ====
rtl/vec_pkg.sv
rtl/fifo_4w2r.sv
rtl/vec_decode.sv
rtl/vec_alu.sv
rtl/vec_vrf.sv
rtl/vec_retire.sv
rtl/vec_backend.sv
sim/tb_vec_backend.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f vec_backend.f \
		--top-module tb_vec_backend -Mdir obj_dir
	./obj_dir/Vtb_vec_backend > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TB FAILED" sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
